// File: core_control.f
hdl/definitions.sv
hdl/decode.sv
hdl/forwarding.sv
hdl/control.sv
hdl/store_buffer.sv
hdl/core_control.sv
sim/clock_gen.sv
sim/core_control_tb.sv

// File: hdl/control.sv
`timescale 1ns/1ps

module control (
	input definitions::pipeline_id_reg_t id_reg_i,
	input definitions::pipeline_ex_reg_t ex_reg_i,
	input definitions::pipeline_mem_reg_t mem_reg_i,
	input definitions::pipeline_wb_reg_t wb_reg_i,
	input logic icache_hit_i,
	input logic dcache_hit_i,
	input logic sb_full_i,
	input logic sb_empty_i,
	input logic sb_snoop_hit_i,
	input logic sb_snoop_line_conflict_i,
	output definitions::pipeline_control_t control_o
);
	import definitions::*;

	decode_out_t decode_out;
	bypass_sel_t rs1_bypass;
	bypass_sel_t rs2_bypass;
	logic rs1_hazard;
	logic rs2_hazard;
	logic data_hazard;
	logic control_hazard;
	logic icache_busy;

	decode decode (
		.instr_i(id_reg_i.instr),
		.decode_o(decode_out)
	);

	forwarding forwarding (
		.id_instr_i(id_reg_i.instr),
		.id_decode_i(decode_out),
		.ex_reg_i(ex_reg_i),
		.mem_reg_i(mem_reg_i),
		.wb_reg_i(wb_reg_i),
		.rs1_bypass_o(rs1_bypass),
		.rs2_bypass_o(rs2_bypass),
		.rs1_hazard_o(rs1_hazard),
		.rs2_hazard_o(rs2_hazard)
	);

	// a bypass on one operand does not cover the other one.
	assign data_hazard = rs1_hazard || rs2_hazard;
	assign icache_busy = !icache_hit_i;

	// taken branches and jumps resolve in MEM.
	assign control_hazard = mem_reg_i.valid &&
		(mem_reg_i.is_jump || (mem_reg_i.is_branch && mem_reg_i.cmp_unit_res));

	logic valid_mem_access;
	logic valid_load;
	logic valid_store;
	logic load_line_conflict;
	logic load_miss_sb_miss;
	logic store_sb_full;
	logic stall_full;
	logic sb_drain;

	assign valid_mem_access = mem_reg_i.valid && mem_reg_i.is_mem_access;
	assign valid_load = valid_mem_access && !mem_reg_i.dcache_wr_enable;
	assign valid_store = valid_mem_access && mem_reg_i.dcache_wr_enable;

	assign load_line_conflict = valid_load && sb_snoop_line_conflict_i;
	assign load_miss_sb_miss = valid_load && !dcache_hit_i && !sb_snoop_hit_i;
	assign store_sb_full = valid_store && sb_full_i;
	assign stall_full = load_line_conflict || load_miss_sb_miss || store_sb_full;

	// the buffer empties while MEM is idle, and also makes room for a
	// load that touches a line with a pending store.
	assign sb_drain = (!valid_load && !sb_empty_i) || load_line_conflict;

	always_comb begin
		control_o = '0;
		control_o.next_pc_sel = control_hazard ? ALU_OUT : PC_4;
		control_o.rs1_bypass = rs1_bypass;
		control_o.rs2_bypass = rs2_bypass;
		control_o.decode_out = decode_out;

		control_o.pc_reg_stall = (data_hazard && !control_hazard) || icache_busy ||
			stall_full;
		control_o.id_reg_stall = (data_hazard && !control_hazard) || stall_full;
		control_o.id_reg_valid = !control_hazard && !icache_busy;

		control_o.ex_reg_stall = stall_full;
		control_o.ex_reg_valid = id_reg_i.valid && !data_hazard && !control_hazard &&
			!decode_out.is_muldiv;

		control_o.mem_reg_stall = stall_full || (icache_busy && control_hazard);
		control_o.mem_reg_valid = ex_reg_i.valid && !control_hazard;
		control_o.wb_reg_valid = mem_reg_i.valid && !stall_full;

		control_o.mul_m0_reg_stall = stall_full;
		control_o.mul_m0_reg_valid = id_reg_i.valid && !data_hazard && !control_hazard &&
			decode_out.is_muldiv;

		control_o.mem_valid_load = valid_load;
		control_o.mem_sb_put_enable = valid_store && !sb_full_i;
		control_o.mem_sb_get_enable = sb_drain;
		control_o.mem_use_sb_snoop_data = valid_load && sb_snoop_hit_i;
	end
endmodule

// File: hdl/core_control.sv
`timescale 1ns/1ps

module core_control (
	input logic clk_i,
	input logic rst_i,
	input definitions::pipeline_id_reg_t id_reg_i,
	input definitions::pipeline_ex_reg_t ex_reg_i,
	input definitions::pipeline_mem_reg_t mem_reg_i,
	input definitions::pipeline_wb_reg_t wb_reg_i,
	input logic icache_hit_i,
	input logic dcache_hit_i,
	output definitions::pipeline_control_t control_o,
	output definitions::sb_drain_t sb_drain_o,
	output definitions::word_t sb_snoop_data_o
);
	logic sb_full;
	logic sb_empty;
	logic sb_snoop_hit;
	logic sb_snoop_line_conflict;

	control control (
		.id_reg_i(id_reg_i),
		.ex_reg_i(ex_reg_i),
		.mem_reg_i(mem_reg_i),
		.wb_reg_i(wb_reg_i),
		.icache_hit_i(icache_hit_i),
		.dcache_hit_i(dcache_hit_i),
		.sb_full_i(sb_full),
		.sb_empty_i(sb_empty),
		.sb_snoop_hit_i(sb_snoop_hit),
		.sb_snoop_line_conflict_i(sb_snoop_line_conflict),
		.control_o(control_o)
	);

	// the MEM-stage address is both the store target and the load snoop.
	store_buffer store_buffer (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.put_i(control_o.mem_sb_put_enable),
		.get_i(control_o.mem_sb_get_enable),
		.put_addr_i(mem_reg_i.mem_addr),
		.put_data_i(mem_reg_i.store_data),
		.snoop_addr_i(mem_reg_i.mem_addr),
		.full_o(sb_full),
		.empty_o(sb_empty),
		.snoop_hit_o(sb_snoop_hit),
		.snoop_line_conflict_o(sb_snoop_line_conflict),
		.snoop_data_o(sb_snoop_data_o),
		.drain_o(sb_drain_o)
	);
endmodule

// File: hdl/decode.sv
`timescale 1ns/1ps

module decode (
	input definitions::instr_t instr_i,
	output definitions::decode_out_t decode_o
);
	import definitions::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	// encodings that are reserved in RV32IM leave every flag low.
	always_comb begin
		decode_o = '0;
		case (opcode)
			OPC_LUI, OPC_AUIPC: begin
				decode_o.regfile_we = 1'b1;
			end
			OPC_JAL: begin
				decode_o.regfile_we = 1'b1;
				decode_o.is_jump = 1'b1;
			end
			OPC_JALR: begin
				if (funct3 == 3'b000) begin
					decode_o.rs1_used = 1'b1;
					decode_o.regfile_we = 1'b1;
					decode_o.is_jump = 1'b1;
				end
			end
			OPC_BRANCH: begin
				if (funct3[2:1] != 2'b01) begin
					decode_o.rs1_used = 1'b1;
					decode_o.rs2_used = 1'b1;
					decode_o.is_branch = 1'b1;
				end
			end
			OPC_LOAD: begin
				if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
					decode_o.rs1_used = 1'b1;
					decode_o.regfile_we = 1'b1;
					decode_o.is_load = 1'b1;
				end
			end
			OPC_STORE: begin
				if (!funct3[2] && funct3[1:0] != 2'b11) begin
					decode_o.rs1_used = 1'b1;
					decode_o.rs2_used = 1'b1;
					decode_o.is_store = 1'b1;
				end
			end
			OPC_OP_IMM: begin
				decode_o.rs1_used = 1'b1;
				decode_o.regfile_we = 1'b1;
			end
			OPC_OP: begin
				// only ADD/SUB and SRL/SRA have an alternate funct7.
				if (funct7 == F7_MULDIV || funct7 == F7_BASE ||
				    (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101))) begin
					decode_o.rs1_used = 1'b1;
					decode_o.rs2_used = 1'b1;
					decode_o.regfile_we = 1'b1;
					decode_o.is_muldiv = (funct7 == F7_MULDIV);
				end
			end
			default: begin
				decode_o = '0;
			end
		endcase
	end
endmodule

// File: hdl/definitions.sv
package definitions;

	localparam int XLEN = 32;
	localparam int SB_DEPTH = 4;
	localparam int SB_PTR_BITS = $clog2(SB_DEPTH);
	localparam int SB_CNT_BITS = $clog2(SB_DEPTH + 1);
	// byte offset inside a 32-bit word, and inside a 16-byte cache line.
	localparam int WORD_OFFSET_BITS = 2;
	localparam int LINE_OFFSET_BITS = 4;

	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT = 7'b0100000;
	localparam logic [6:0] F7_MULDIV = 7'b0000001;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [31:0] instr_t;
	typedef logic [4:0] reg_addr_t;

	typedef enum logic [1:0] {
		PC_4,
		ALU_OUT
	} next_pc_sel_t;

	typedef enum logic [1:0] {
		NONE,
		EX,
		MEM,
		WB
	} bypass_sel_t;

	typedef struct packed {
		logic rs1_used;
		logic rs2_used;
		logic regfile_we;
		logic is_load;
		logic is_store;
		logic is_branch;
		logic is_jump;
		logic is_muldiv;
	} decode_out_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		instr_t instr;
	} pipeline_id_reg_t;

	typedef struct packed {
		logic valid;
		logic regfile_we;
		reg_addr_t regfile_wr_addr;
		logic is_mem_access;
		logic dcache_wr_enable;
		logic is_branch;
		logic is_jump;
	} pipeline_ex_reg_t;

	typedef struct packed {
		logic valid;
		logic regfile_we;
		reg_addr_t regfile_wr_addr;
		logic is_mem_access;
		logic dcache_wr_enable;
		logic is_branch;
		logic is_jump;
		logic cmp_unit_res;
		word_t mem_addr;
		word_t store_data;
	} pipeline_mem_reg_t;

	typedef struct packed {
		logic valid;
		logic regfile_we;
		reg_addr_t regfile_wr_addr;
	} pipeline_wb_reg_t;

	typedef struct packed {
		next_pc_sel_t next_pc_sel;
		bypass_sel_t rs1_bypass;
		bypass_sel_t rs2_bypass;
		decode_out_t decode_out;
		logic pc_reg_stall;
		logic id_reg_stall;
		logic id_reg_valid;
		logic ex_reg_stall;
		logic ex_reg_valid;
		logic mem_reg_stall;
		logic mem_reg_valid;
		logic wb_reg_valid;
		logic mul_m0_reg_stall;
		logic mul_m0_reg_valid;
		logic mem_valid_load;
		logic mem_sb_put_enable;
		logic mem_sb_get_enable;
		logic mem_use_sb_snoop_data;
	} pipeline_control_t;

	typedef struct packed {
		logic valid;
		word_t addr;
		word_t data;
	} sb_drain_t;

	// bit 0 flags a match on rs1, bit 1 a match on rs2.
	function automatic logic [1:0] data_hazard_raw_check(
		input instr_t instr,
		input decode_out_t dec,
		input reg_addr_t rd
	);
		logic [1:0] match;
		match[0] = dec.rs1_used && (instr[19:15] == rd) && (rd != '0);
		match[1] = dec.rs2_used && (instr[24:20] == rd) && (rd != '0);
		return match;
	endfunction

endpackage

// File: hdl/forwarding.sv
`timescale 1ns/1ps

module forwarding (
	input definitions::instr_t id_instr_i,
	input definitions::decode_out_t id_decode_i,
	input definitions::pipeline_ex_reg_t ex_reg_i,
	input definitions::pipeline_mem_reg_t mem_reg_i,
	input definitions::pipeline_wb_reg_t wb_reg_i,
	output definitions::bypass_sel_t rs1_bypass_o,
	output definitions::bypass_sel_t rs2_bypass_o,
	output logic rs1_hazard_o,
	output logic rs2_hazard_o
);
	import definitions::*;

	logic [1:0] ex_match;
	logic [1:0] mem_match;
	logic [1:0] wb_match;
	bypass_sel_t bypass [2];
	logic [1:0] hazard;

	assign ex_match = (ex_reg_i.valid && ex_reg_i.regfile_we) ?
		data_hazard_raw_check(id_instr_i, id_decode_i, ex_reg_i.regfile_wr_addr) : 2'b00;
	assign mem_match = (mem_reg_i.valid && mem_reg_i.regfile_we) ?
		data_hazard_raw_check(id_instr_i, id_decode_i, mem_reg_i.regfile_wr_addr) : 2'b00;
	assign wb_match = (wb_reg_i.valid && wb_reg_i.regfile_we) ?
		data_hazard_raw_check(id_instr_i, id_decode_i, wb_reg_i.regfile_wr_addr) : 2'b00;

	// the youngest writer decides, and a load there has no data before WB.
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			bypass[i] = NONE;
			hazard[i] = 1'b0;
			if (ex_match[i]) begin
				if (ex_reg_i.is_mem_access)
					hazard[i] = 1'b1;
				else
					bypass[i] = EX;
			end else if (mem_match[i]) begin
				if (mem_reg_i.is_mem_access)
					hazard[i] = 1'b1;
				else
					bypass[i] = MEM;
			end else if (wb_match[i]) begin
				bypass[i] = WB;
			end
		end
	end

	assign rs1_bypass_o = bypass[0];
	assign rs2_bypass_o = bypass[1];
	assign rs1_hazard_o = hazard[0];
	assign rs2_hazard_o = hazard[1];
endmodule

// File: hdl/store_buffer.sv
`timescale 1ns/1ps

module store_buffer (
	input logic clk_i,
	input logic rst_i,
	input logic put_i,
	input logic get_i,
	input definitions::word_t put_addr_i,
	input definitions::word_t put_data_i,
	input definitions::word_t snoop_addr_i,
	output logic full_o,
	output logic empty_o,
	output logic snoop_hit_o,
	output logic snoop_line_conflict_o,
	output definitions::word_t snoop_data_o,
	output definitions::sb_drain_t drain_o
);
	import definitions::*;

	word_t addr_q [SB_DEPTH];
	word_t data_q [SB_DEPTH];
	logic [SB_PTR_BITS-1:0] wr_ptr_q;
	logic [SB_PTR_BITS-1:0] rd_ptr_q;
	logic [SB_CNT_BITS-1:0] count_q;
	logic [SB_PTR_BITS-1:0] snoop_idx;

	always_ff @(posedge clk_i) begin
		if (put_i) begin
			addr_q[wr_ptr_q] <= put_addr_i;
			data_q[wr_ptr_q] <= put_data_i;
		end
	end

	// pointers wrap on their own since the depth is a power of two.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (put_i)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (get_i)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			if (put_i && !get_i)
				count_q <= count_q + 1'b1;
			else if (get_i && !put_i)
				count_q <= count_q - 1'b1;
		end
	end

	assign full_o = (count_q == SB_CNT_BITS'(SB_DEPTH));
	assign empty_o = (count_q == '0);

	// entries are walked oldest first, so the youngest hit sets the data last.
	always_comb begin
		snoop_idx = rd_ptr_q;
		snoop_hit_o = 1'b0;
		snoop_line_conflict_o = 1'b0;
		snoop_data_o = '0;
		for (int k = 0; k < SB_DEPTH; k++) begin
			snoop_idx = rd_ptr_q + SB_PTR_BITS'(k);
			if (k < count_q) begin
				if (addr_q[snoop_idx][XLEN-1:WORD_OFFSET_BITS] ==
				    snoop_addr_i[XLEN-1:WORD_OFFSET_BITS]) begin
					snoop_hit_o = 1'b1;
					snoop_data_o = data_q[snoop_idx];
				end else if (addr_q[snoop_idx][XLEN-1:LINE_OFFSET_BITS] ==
					     snoop_addr_i[XLEN-1:LINE_OFFSET_BITS]) begin
					snoop_line_conflict_o = 1'b1;
				end
			end
		end
	end

	always_comb begin
		drain_o.valid = get_i;
		drain_o.addr = addr_q[rd_ptr_q];
		drain_o.data = data_q[rd_ptr_q];
	end
endmodule

// File: sim/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
	parameter real PERIOD_NS = 20.0,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_o,
	output logic rst_o
);
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
	end

	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0;
	end
endmodule

// File: sim/core_control_tb.sv
`timescale 1ns/1ps

module core_control_tb;
	import definitions::*;

	localparam int RESET_CYCLES = 8;
	// rs1_used, rs2_used, regfile_we, is_load, is_store, is_branch, is_jump, is_muldiv.
	localparam decode_out_t DEC_ALU_R = 8'b1110_0000;
	localparam decode_out_t DEC_MUL = 8'b1110_0001;

	typedef struct packed {
		pipeline_id_reg_t id_reg;
		pipeline_ex_reg_t ex_reg;
		pipeline_mem_reg_t mem_reg;
		pipeline_wb_reg_t wb_reg;
		logic icache_hit;
		logic dcache_hit;
		pipeline_control_t exp_ctrl;
		sb_drain_t exp_drain;
		word_t exp_snoop;
	} row_t;

	logic clk;
	logic rst;
	pipeline_id_reg_t id_reg;
	pipeline_ex_reg_t ex_reg;
	pipeline_mem_reg_t mem_reg;
	pipeline_wb_reg_t wb_reg;
	logic icache_hit;
	logic dcache_hit;
	pipeline_control_t control;
	sb_drain_t sb_drain;
	word_t sb_snoop_data;

	row_t rows[$];
	string names[$];
	int passed_rows = 0;
	int failed_rows = 0;
	int cycle_count = 0;
	int timeout_limit = 0;
	int unsigned seed;

	clock_gen #(.PERIOD_NS(20.0), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
		.clk_o(clk),
		.rst_o(rst)
	);

	core_control u_dut (
		.clk_i(clk),
		.rst_i(rst),
		.id_reg_i(id_reg),
		.ex_reg_i(ex_reg),
		.mem_reg_i(mem_reg),
		.wb_reg_i(wb_reg),
		.icache_hit_i(icache_hit),
		.dcache_hit_i(dcache_hit),
		.control_o(control),
		.sb_drain_o(sb_drain),
		.sb_snoop_data_o(sb_snoop_data)
	);

	// R-type word on the OP opcode with funct3 zero.
	function automatic instr_t alu_instr(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
		reg_addr_t rd);
		return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
	endfunction

	// x0 and the source registers x1 and x2 never come out of here.
	function automatic reg_addr_t free_reg();
		return reg_addr_t'($urandom_range(31, 3));
	endfunction

	function automatic sb_drain_t drain_of(word_t addr, word_t data);
		sb_drain_t d;
		d.valid = 1'b1;
		d.addr = addr;
		d.data = data;
		return d;
	endfunction

	// every stage busy with an ALU op that no ID operand depends on.
	function automatic row_t base_row();
		row_t r;
		r = '0;
		r.id_reg.valid = 1'b1;
		r.id_reg.pc = 32'h0000_0080;
		r.id_reg.instr = alu_instr(7'b0000000, 5'd2, 5'd1, 5'd3);
		r.ex_reg.valid = 1'b1;
		r.ex_reg.regfile_we = 1'b1;
		r.ex_reg.regfile_wr_addr = free_reg();
		r.mem_reg.valid = 1'b1;
		r.mem_reg.regfile_we = 1'b1;
		r.mem_reg.regfile_wr_addr = free_reg();
		r.wb_reg.valid = 1'b1;
		r.wb_reg.regfile_we = 1'b1;
		r.wb_reg.regfile_wr_addr = free_reg();
		r.icache_hit = 1'b1;
		r.dcache_hit = 1'b1;
		r.exp_ctrl.next_pc_sel = PC_4;
		r.exp_ctrl.rs1_bypass = NONE;
		r.exp_ctrl.rs2_bypass = NONE;
		r.exp_ctrl.decode_out = DEC_ALU_R;
		r.exp_ctrl.id_reg_valid = 1'b1;
		r.exp_ctrl.ex_reg_valid = 1'b1;
		r.exp_ctrl.mem_reg_valid = 1'b1;
		r.exp_ctrl.wb_reg_valid = 1'b1;
		return r;
	endfunction

	function automatic row_t store_row(word_t addr, word_t data);
		row_t r;
		r = base_row();
		r.mem_reg.regfile_we = 1'b0;
		r.mem_reg.is_mem_access = 1'b1;
		r.mem_reg.dcache_wr_enable = 1'b1;
		r.mem_reg.mem_addr = addr;
		r.mem_reg.store_data = data;
		r.exp_ctrl.mem_sb_put_enable = 1'b1;
		return r;
	endfunction

	function automatic row_t load_row(word_t addr, logic hit);
		row_t r;
		r = base_row();
		r.mem_reg.is_mem_access = 1'b1;
		r.mem_reg.mem_addr = addr;
		r.dcache_hit = hit;
		r.exp_ctrl.mem_valid_load = 1'b1;
		return r;
	endfunction

	// a full stall freezes every stage and holds the MEM result back from WB.
	function automatic row_t full_stall(row_t r);
		row_t s;
		s = r;
		s.exp_ctrl.pc_reg_stall = 1'b1;
		s.exp_ctrl.id_reg_stall = 1'b1;
		s.exp_ctrl.ex_reg_stall = 1'b1;
		s.exp_ctrl.mem_reg_stall = 1'b1;
		s.exp_ctrl.mul_m0_reg_stall = 1'b1;
		s.exp_ctrl.wb_reg_valid = 1'b0;
		return s;
	endfunction

	task automatic add_row(string name, row_t r);
		names.push_back(name);
		rows.push_back(r);
	endtask

	task automatic build_table();
		row_t r;
		r = base_row();
		r.ex_reg.regfile_wr_addr = 5'd1;
		r.mem_reg.regfile_wr_addr = 5'd1;
		r.wb_reg.regfile_wr_addr = 5'd1;
		r.exp_ctrl.rs1_bypass = EX;
		add_row("fwd_rs1_ex_first", r);
		r = base_row();
		r.wb_reg.regfile_wr_addr = 5'd2;
		r.exp_ctrl.rs2_bypass = WB;
		add_row("fwd_rs2_wb", r);
		r = base_row();
		r.ex_reg.regfile_wr_addr = 5'd1;
		r.ex_reg.is_mem_access = 1'b1;
		r.exp_ctrl.pc_reg_stall = 1'b1;
		r.exp_ctrl.id_reg_stall = 1'b1;
		r.exp_ctrl.ex_reg_valid = 1'b0;
		add_row("load_use_rs1", r);
		r = base_row();
		r.id_reg.instr = alu_instr(7'b0000001, 5'd2, 5'd1, 5'd3);
		r.exp_ctrl.decode_out = DEC_MUL;
		r.exp_ctrl.ex_reg_valid = 1'b0;
		r.exp_ctrl.mul_m0_reg_valid = 1'b1;
		add_row("mul_to_m0", r);
		r = base_row();
		r.id_reg.instr = alu_instr(7'b0100000, 5'd2, 5'd1, 5'd3);
		add_row("sub_decoded", r);
		for (int j = 0; j < 2; j++) begin
			r = base_row();
			r.mem_reg.regfile_we = 1'b0;
			r.mem_reg.is_branch = (j == 0);
			r.mem_reg.is_jump = (j == 1);
			r.mem_reg.cmp_unit_res = (j == 0);
			r.exp_ctrl.next_pc_sel = ALU_OUT;
			r.exp_ctrl.id_reg_valid = 1'b0;
			r.exp_ctrl.ex_reg_valid = 1'b0;
			r.exp_ctrl.mem_reg_valid = 1'b0;
			add_row(j == 0 ? "branch_taken" : "jump_in_mem", r);
		end
		r = base_row();
		r.mem_reg.regfile_we = 1'b0;
		r.mem_reg.is_branch = 1'b1;
		add_row("branch_not_taken", r);
		r = base_row();
		r.icache_hit = 1'b0;
		r.exp_ctrl.pc_reg_stall = 1'b1;
		r.exp_ctrl.id_reg_valid = 1'b0;
		add_row("icache_miss", r);

		// the buffer drains whenever MEM holds no load, so it never grows past one entry.
		r = store_row(32'h0000_0100, 32'h0000_00a0);
		add_row("store_first", r);
		r = store_row(32'h0000_0104, 32'h0000_00b0);
		r.exp_ctrl.mem_sb_get_enable = 1'b1;
		r.exp_drain = drain_of(32'h0000_0100, 32'h0000_00a0);
		add_row("store_second_drains_first", r);
		r = store_row(32'h0000_0208, 32'h0000_00c0);
		r.exp_ctrl.mem_sb_get_enable = 1'b1;
		r.exp_drain = drain_of(32'h0000_0104, 32'h0000_00b0);
		add_row("store_third_drains_second", r);
		r = load_row(32'h0000_0208, 1'b0);
		r.exp_ctrl.mem_use_sb_snoop_data = 1'b1;
		r.exp_snoop = 32'h0000_00c0;
		add_row("load_snoop_hit", r);
		r = full_stall(load_row(32'h0000_020c, 1'b1));
		r.exp_ctrl.mem_sb_get_enable = 1'b1;
		r.exp_drain = drain_of(32'h0000_0208, 32'h0000_00c0);
		add_row("load_line_conflict", r);
		r = load_row(32'h0000_020c, 1'b1);
		add_row("load_after_drain", r);
		r = full_stall(load_row(32'h0000_0300, 1'b0));
		add_row("load_miss_stall", r);
		r = load_row(32'h0000_0300, 1'b1);
		add_row("load_miss_filled", r);
		r = store_row(32'h0000_0400, 32'h0000_00d0);
		add_row("store_before_idle", r);
		r = base_row();
		r.mem_reg.valid = 1'b0;
		r.exp_ctrl.wb_reg_valid = 1'b0;
		r.exp_ctrl.mem_sb_get_enable = 1'b1;
		r.exp_drain = drain_of(32'h0000_0400, 32'h0000_00d0);
		add_row("idle_drain", r);
		r = base_row();
		r.mem_reg.valid = 1'b0;
		r.exp_ctrl.wb_reg_valid = 1'b0;
		add_row("idle_empty", r);
	endtask

	task automatic apply_row(row_t r);
		id_reg = r.id_reg;
		ex_reg = r.ex_reg;
		mem_reg = r.mem_reg;
		wb_reg = r.wb_reg;
		icache_hit = r.icache_hit;
		dcache_hit = r.dcache_hit;
	endtask

	task automatic check_row(string name, row_t r);
		logic ok;
		ok = 1'b1;
		if (control !== r.exp_ctrl) begin
			$display("CHECK FAILED %s control: expected %h actual %h", name, r.exp_ctrl, control);
			ok = 1'b0;
		end
		if (sb_drain.valid !== r.exp_drain.valid ||
		    (r.exp_drain.valid && sb_drain !== r.exp_drain)) begin
			$display("CHECK FAILED %s drain: expected %h actual %h", name, r.exp_drain,
				sb_drain);
			ok = 1'b0;
		end
		if (r.exp_ctrl.mem_use_sb_snoop_data && sb_snoop_data !== r.exp_snoop) begin
			$display("CHECK FAILED %s snoop data: expected %h actual %h", name, r.exp_snoop,
				sb_snoop_data);
			ok = 1'b0;
		end
		if (ok) begin
			passed_rows++;
			$display("%-28s pass", name);
		end else begin
			failed_rows++;
			$display("%-28s fail", name);
		end
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
			$display("timeout: the table did not finish within %0d cycles", timeout_limit);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		seed = $urandom(63423);
		id_reg = '0;
		ex_reg = '0;
		mem_reg = '0;
		wb_reg = '0;
		icache_hit = 1'b1;
		dcache_hit = 1'b1;
		build_table();
		timeout_limit = 2 * (rows.size() + RESET_CYCLES) + 20;
		wait (rst == 1'b0);
		for (int i = 0; i < rows.size(); i++) begin
			@(posedge clk);
			#2;
			apply_row(rows[i]);
			#16;
			check_row(names[i], rows[i]);
		end
		$display("rows %0d, passed %0d, failed %0d", rows.size(), passed_rows, failed_rows);
		if (failed_rows == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end
endmodule
